// File: include/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define XLEN       32
`define REG_COUNT  32
`define DMEM_WORDS 64

// major opcodes of the supported instruction classes.
`define OP_R    7'b0110011
`define OP_I    7'b0010011
`define OP_S    7'b0100011
`define OP_B    7'b1100011
`define OP_U    7'b0110111
`define OP_J    7'b1101111
`define OP_LW   7'b0000011
`define OP_JALR 7'b1100111

// branch conditions as carried in funct3.
`define F3_BEQ 3'b000
`define F3_BNE 3'b001
`define F3_BLT 3'b010
`define F3_BGE 3'b011

`endif

// File: rtl/corePkg.sv
package corePkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } aluOpT;

    // where the write-back value of an instruction comes from.
    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4,
        RES_IMM
    } resultSrcT;

    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE} branchT;

    typedef enum logic [1:0] {JMP_NONE, JMP_JAL, JMP_JALR} jumpT;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_J, IMM_U} immSrcT;

endpackage

// File: rtl/mainController.sv
`include "core_defs.svh"

module mainController
    import corePkg::*;
(
    input  logic [6:0] op,
    input  logic [2:0] funct3,
    output logic       regWrite,
    output resultSrcT  resultSrc,
    output logic       memWrite,
    output jumpT       jump,
    output branchT     branch,
    output logic       aluSrc,
    output immSrcT     immSrc,
    output logic [1:0] aluClass,  // 00 add, 01 branch, 10 register, 11 immediate.
    output logic       illegal
);

    always_comb begin
        regWrite  = 1'b0;
        resultSrc = RES_ALU;
        memWrite  = 1'b0;
        jump      = JMP_NONE;
        branch    = BR_NONE;
        aluSrc    = 1'b0;
        immSrc    = IMM_I;
        aluClass  = 2'b00;
        illegal   = 1'b0;
        case (op)
            `OP_R: begin
                regWrite = 1'b1;
                aluClass = 2'b10;
            end
            `OP_I: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluClass = 2'b11;
            end
            `OP_S: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = IMM_S;
            end
            `OP_B: begin
                immSrc   = IMM_B;
                aluClass = 2'b01;
                case (funct3)
                    `F3_BEQ: branch = BR_EQ;
                    `F3_BNE: branch = BR_NE;
                    `F3_BLT: branch = BR_LT;
                    `F3_BGE: branch = BR_GE;
                    default: illegal = 1'b1;  // unsigned compares are not supported.
                endcase
            end
            `OP_U: begin
                regWrite  = 1'b1;
                resultSrc = RES_IMM;
                immSrc    = IMM_U;
            end
            `OP_J: begin
                regWrite  = 1'b1;
                resultSrc = RES_PC4;
                immSrc    = IMM_J;
                jump      = JMP_JAL;
            end
            `OP_LW: begin
                regWrite  = 1'b1;
                resultSrc = RES_MEM;
                aluSrc    = 1'b1;
            end
            `OP_JALR: begin
                regWrite  = 1'b1;
                resultSrc = RES_PC4;
                aluSrc    = 1'b1;
                jump      = JMP_JALR;
            end
            default: illegal = 1'b1;
        endcase
    end

    // no instruction class both stores and writes a register.
    always_comb begin
        assert (!(memWrite && regWrite))
            else $error("mainController: memWrite and regWrite both set for op %h", op);
    end

endmodule

// File: rtl/regFile.sv
`include "core_defs.svh"

module regFile (
    input  logic              clk,
    input  logic              arstN,
    input  logic [4:0]        rs1,
    input  logic [4:0]        rs2,
    input  logic              we,
    input  logic [`XLEN-1:0]  wd,
    input  logic [4:0]        rd,
    output logic [`XLEN-1:0]  rd1,
    output logic [`XLEN-1:0]  rd2
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wd;
        end
    end

    // a write in this cycle is visible to the reader at once.
    assign rd1 = (rs1 == 5'd0) ? '0 : (we && rd == rs1) ? wd : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : (we && rd == rs2) ? wd : regs[rs2];

endmodule

// File: rtl/decodeStage.sv
`include "core_defs.svh"

module decodeStage
    import corePkg::*;
(
    input  logic              clk,
    input  logic              arstN,
    input  logic              instrValid,
    input  logic [31:0]       instr,
    input  logic [`XLEN-1:0]  pc,
    input  logic [`XLEN-1:0]  rd1,
    input  logic [`XLEN-1:0]  rd2,
    output logic [4:0]        rs1,
    output logic [4:0]        rs2,
    output logic              dValid,
    output logic              dRegWrite,
    output logic              dMemWrite,
    output resultSrcT         dResultSrc,
    output jumpT              dJump,
    output branchT            dBranch,
    output logic              dAluSrc,
    output aluOpT             dAluOp,
    output logic [4:0]        dRd,
    output logic [4:0]        dRs1,
    output logic [4:0]        dRs2,
    output logic [`XLEN-1:0]  dA,
    output logic [`XLEN-1:0]  dB,
    output logic [`XLEN-1:0]  dImm,
    output logic [`XLEN-1:0]  dPc,
    output logic              dIllegal
);

    logic [2:0]       funct3;
    logic             regWrite, memWrite, aluSrc, illegal;
    resultSrcT        resultSrc;
    jumpT             jump;
    branchT           branch;
    immSrcT           immSrc;
    logic [1:0]       aluClass;
    aluOpT            aluOp;
    logic [`XLEN-1:0] imm;

    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    mainController ctrl (
        .op(instr[6:0]), .funct3(funct3), .regWrite(regWrite), .resultSrc(resultSrc),
        .memWrite(memWrite), .jump(jump), .branch(branch), .aluSrc(aluSrc),
        .immSrc(immSrc), .aluClass(aluClass), .illegal(illegal)
    );

    // only register and immediate classes look at funct3, everything else adds.
    always_comb begin
        aluOp = ALU_ADD;
        if (aluClass[1]) begin
            case (funct3)
                3'b000:  aluOp = (aluClass == 2'b10 && instr[30]) ? ALU_SUB : ALU_ADD;
                3'b001:  aluOp = ALU_SLL;
                3'b010:  aluOp = ALU_SLT;
                3'b011:  aluOp = ALU_SLTU;
                3'b100:  aluOp = ALU_XOR;
                3'b101:  aluOp = instr[30] ? ALU_SRA : ALU_SRL;
                3'b110:  aluOp = ALU_OR;
                default: aluOp = ALU_AND;
            endcase
        end
    end

    always_comb begin
        case (immSrc)
            IMM_S:   imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   imm = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            IMM_J:   imm = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            IMM_U:   imm = {instr[31:12], 12'b0};
            default: imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dValid    <= 1'b0;
            dRegWrite <= 1'b0;
            dMemWrite <= 1'b0;
            dJump     <= JMP_NONE;
            dBranch   <= BR_NONE;
            dIllegal  <= 1'b0;
        end else begin
            dValid    <= instrValid && !illegal;  // an illegal opcode leaves a bubble.
            dRegWrite <= instrValid && regWrite;
            dMemWrite <= instrValid && memWrite;
            dJump     <= instrValid ? jump : JMP_NONE;
            dBranch   <= instrValid ? branch : BR_NONE;
            dIllegal  <= instrValid && illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            dResultSrc <= resultSrc;
            dAluSrc    <= aluSrc;
            dAluOp     <= aluOp;
            dRd        <= instr[11:7];
            dRs1       <= rs1;
            dRs2       <= rs2;
            dA         <= rd1;
            dB         <= rd2;
            dImm       <= imm;
            dPc        <= pc;
        end
    end

endmodule

// File: rtl/executeStage.sv
`include "core_defs.svh"

module executeStage
    import corePkg::*;
(
    input  logic              clk,
    input  logic              arstN,
    input  logic              dValid,
    input  logic              dRegWrite,
    input  logic              dMemWrite,
    input  resultSrcT         dResultSrc,
    input  jumpT              dJump,
    input  branchT            dBranch,
    input  logic              dAluSrc,
    input  aluOpT             dAluOp,
    input  logic [4:0]        dRd,
    input  logic [4:0]        dRs1,
    input  logic [4:0]        dRs2,
    input  logic [`XLEN-1:0]  dA,
    input  logic [`XLEN-1:0]  dB,
    input  logic [`XLEN-1:0]  dImm,
    input  logic [`XLEN-1:0]  dPc,
    input  logic              dIllegal,
    input  logic              wbEn,
    input  logic [4:0]        wbRd,
    input  logic [`XLEN-1:0]  wbValue,
    output logic              eValid,
    output logic              eRegWrite,
    output logic              eMemWrite,
    output resultSrcT         eResultSrc,
    output logic [4:0]        eRd,
    output logic [`XLEN-1:0]  eAlu,
    output logic [`XLEN-1:0]  eStore,
    output logic [`XLEN-1:0]  eLink,
    output logic [`XLEN-1:0]  eImm,
    output logic              eIllegal,
    output logic              redirectValid,
    output logic [`XLEN-1:0]  redirectPc
);

    logic [`XLEN-1:0] fwdA, fwdB, opB, aluOut, jalrSum, target;
    logic             taken, redirect;

    // the instruction one ahead is in the result stage and has the newest value.
    assign fwdA = (wbEn && wbRd == dRs1 && dRs1 != 5'd0) ? wbValue : dA;
    assign fwdB = (wbEn && wbRd == dRs2 && dRs2 != 5'd0) ? wbValue : dB;
    assign opB  = dAluSrc ? dImm : fwdB;

    always_comb begin
        case (dAluOp)
            ALU_SUB:  aluOut = fwdA - opB;
            ALU_AND:  aluOut = fwdA & opB;
            ALU_OR:   aluOut = fwdA | opB;
            ALU_XOR:  aluOut = fwdA ^ opB;
            ALU_SLT:  aluOut = {{(`XLEN-1){1'b0}}, $signed(fwdA) < $signed(opB)};
            ALU_SLTU: aluOut = {{(`XLEN-1){1'b0}}, fwdA < opB};
            ALU_SLL:  aluOut = fwdA << opB[4:0];
            ALU_SRL:  aluOut = fwdA >> opB[4:0];
            ALU_SRA:  aluOut = $signed(fwdA) >>> opB[4:0];
            default:  aluOut = fwdA + opB;
        endcase
    end

    always_comb begin
        case (dBranch)
            BR_EQ:   taken = (fwdA == fwdB);
            BR_NE:   taken = (fwdA != fwdB);
            BR_LT:   taken = ($signed(fwdA) < $signed(fwdB));
            BR_GE:   taken = ($signed(fwdA) >= $signed(fwdB));
            default: taken = 1'b0;
        endcase
    end

    assign jalrSum  = fwdA + dImm;
    assign target   = (dJump == JMP_JALR) ? {jalrSum[`XLEN-1:1], 1'b0} : dPc + dImm;
    assign redirect = dValid && (taken || dJump != JMP_NONE);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            eValid        <= 1'b0;
            eRegWrite     <= 1'b0;
            eMemWrite     <= 1'b0;
            eIllegal      <= 1'b0;
            redirectValid <= 1'b0;
        end else begin
            eValid        <= dValid;
            eRegWrite     <= dRegWrite;
            eMemWrite     <= dMemWrite;
            eIllegal      <= dIllegal;
            redirectValid <= redirect;
        end
    end

    always_ff @(posedge clk) begin
        eResultSrc <= dResultSrc;
        eRd        <= dRd;
        eAlu       <= aluOut;
        eStore     <= fwdB;
        eLink      <= dPc + `XLEN'(4);
        eImm       <= dImm;
        redirectPc <= target;
    end

    // a redirecting instruction never stores and writes back nothing but its link value.
    assert property (@(posedge clk) disable iff (!arstN)
        redirectValid |-> !eMemWrite && (!eRegWrite || eResultSrc == RES_PC4))
        else $error("executeStage: redirect from an instruction that stores or writes no link");

endmodule

// File: rtl/resultStage.sv
`include "core_defs.svh"

module resultStage
    import corePkg::*;
(
    input  logic              clk,
    input  logic              arstN,
    input  logic              eValid,
    input  logic              eRegWrite,
    input  logic              eMemWrite,
    input  resultSrcT         eResultSrc,
    input  logic [4:0]        eRd,
    input  logic [`XLEN-1:0]  eAlu,
    input  logic [`XLEN-1:0]  eStore,
    input  logic [`XLEN-1:0]  eLink,
    input  logic [`XLEN-1:0]  eImm,
    input  logic              eIllegal,
    output logic              wbEn,
    output logic [4:0]        wbRd,
    output logic [`XLEN-1:0]  wbValue,
    output logic              wbValid,
    output logic [`XLEN-1:0]  wbData,
    output logic [4:0]        wbRdOut,
    output logic              storeValid,
    output logic [`XLEN-1:0]  storeAddr,
    output logic [`XLEN-1:0]  storeData,
    output logic              illegal
);

    localparam int memAddrW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0]    dmem [`DMEM_WORDS];
    logic [memAddrW-1:0] memIdx;
    logic                storeEn;

    assign memIdx  = eAlu[memAddrW+1:2];  // word address, byte offset ignored.
    assign storeEn = eValid && eMemWrite;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (storeEn) begin
            dmem[memIdx] <= eStore;
        end
    end

    always_comb begin
        case (eResultSrc)
            RES_MEM: wbValue = dmem[memIdx];
            RES_PC4: wbValue = eLink;
            RES_IMM: wbValue = eImm;
            default: wbValue = eAlu;
        endcase
    end

    // x0 never produces a write-back.
    assign wbEn = eValid && eRegWrite && eRd != 5'd0;
    assign wbRd = eRd;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbValid    <= 1'b0;
            storeValid <= 1'b0;
            illegal    <= 1'b0;
        end else begin
            wbValid    <= wbEn;
            storeValid <= storeEn;
            illegal    <= eIllegal;
        end
    end

    always_ff @(posedge clk) begin
        wbData    <= wbValue;
        wbRdOut   <= eRd;
        storeAddr <= eAlu;
        storeData <= eStore;
    end

endmodule

// File: rtl/coreTop.sv
`include "core_defs.svh"

module coreTop
    import corePkg::*;
(
    input  logic              clk,
    input  logic              arstN,
    input  logic              instrValid,
    input  logic [31:0]       instr,
    input  logic [`XLEN-1:0]  pc,
    output logic              wbValid,
    output logic [4:0]        wbRd,
    output logic [`XLEN-1:0]  wbData,
    output logic              redirectValid,
    output logic [`XLEN-1:0]  redirectPc,
    output logic              storeValid,
    output logic [`XLEN-1:0]  storeAddr,
    output logic [`XLEN-1:0]  storeData,
    output logic              illegal
);

    logic [4:0]       rs1, rs2, dRd, dRs1, dRs2, eRd, rfRd;
    logic [`XLEN-1:0] rd1, rd2, dA, dB, dImm, dPc;
    logic [`XLEN-1:0] eAlu, eStore, eLink, eImm, rfWd;
    logic             dValid, dRegWrite, dMemWrite, dAluSrc, dIllegal;
    logic             eValid, eRegWrite, eMemWrite, eIllegal, rfWe;
    resultSrcT        dResultSrc, eResultSrc;
    jumpT             dJump;
    branchT           dBranch;
    aluOpT            dAluOp;

    regFile rf (
        .clk(clk), .arstN(arstN), .rs1(rs1), .rs2(rs2),
        .we(rfWe), .wd(rfWd), .rd(rfRd), .rd1(rd1), .rd2(rd2)
    );

    decodeStage dec (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr), .pc(pc),
        .rd1(rd1), .rd2(rd2), .rs1(rs1), .rs2(rs2), .dValid(dValid),
        .dRegWrite(dRegWrite), .dMemWrite(dMemWrite), .dResultSrc(dResultSrc),
        .dJump(dJump), .dBranch(dBranch), .dAluSrc(dAluSrc), .dAluOp(dAluOp),
        .dRd(dRd), .dRs1(dRs1), .dRs2(dRs2), .dA(dA), .dB(dB), .dImm(dImm),
        .dPc(dPc), .dIllegal(dIllegal)
    );

    executeStage exe (
        .clk(clk), .arstN(arstN), .dValid(dValid), .dRegWrite(dRegWrite),
        .dMemWrite(dMemWrite), .dResultSrc(dResultSrc), .dJump(dJump), .dBranch(dBranch),
        .dAluSrc(dAluSrc), .dAluOp(dAluOp), .dRd(dRd), .dRs1(dRs1), .dRs2(dRs2),
        .dA(dA), .dB(dB), .dImm(dImm), .dPc(dPc), .dIllegal(dIllegal),
        .wbEn(rfWe), .wbRd(rfRd), .wbValue(rfWd),
        .eValid(eValid), .eRegWrite(eRegWrite), .eMemWrite(eMemWrite),
        .eResultSrc(eResultSrc), .eRd(eRd), .eAlu(eAlu), .eStore(eStore),
        .eLink(eLink), .eImm(eImm), .eIllegal(eIllegal),
        .redirectValid(redirectValid), .redirectPc(redirectPc)
    );

    // the write port of the result stage feeds both the register file and forwarding.
    resultStage res (
        .clk(clk), .arstN(arstN), .eValid(eValid), .eRegWrite(eRegWrite),
        .eMemWrite(eMemWrite), .eResultSrc(eResultSrc), .eRd(eRd), .eAlu(eAlu),
        .eStore(eStore), .eLink(eLink), .eImm(eImm), .eIllegal(eIllegal),
        .wbEn(rfWe), .wbRd(rfRd), .wbValue(rfWd), .wbValid(wbValid), .wbData(wbData),
        .wbRdOut(wbRd), .storeValid(storeValid), .storeAddr(storeAddr),
        .storeData(storeData), .illegal(illegal)
    );

endmodule

// File: tests/coreChecker.sv
module coreChecker (
    input logic        clk,
    input logic        arstN,
    input logic        wbValid,
    input logic [4:0]  wbRd,
    input logic [31:0] wbData,
    input logic        redirectValid,
    input logic [31:0] redirectPc,
    input logic        storeValid,
    input logic [31:0] storeAddr,
    input logic [31:0] storeData,
    input logic        illegal
);

    logic [4:0]       expRd [$];
    logic [31:0]      expWb [$];
    logic [31:0]      expRedirect [$];
    logic [31:0]      expAddr [$];
    logic [31:0]      expData [$];
    int               expIllegal = 0;
    int               testErrors = 0;
    int               errorCount = 0;
    int               testCount = 0;
    int               failCount = 0;
    logic [8*16-1:0]  testName = "none";

    task automatic noteError(input string msg);
        $display("%0s (test %0s)", msg, testName);
        testErrors++;
        errorCount++;
    endtask

    task automatic checkValue(input string sig, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            noteError($sformatf("Mismatch %0s: expected %h, got %h", sig, exp, act));
        end
    endtask

    task automatic beginTest(input logic [8*16-1:0] name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic expectWb(input logic [4:0] rd, input logic [31:0] data);
        expRd.push_back(rd);
        expWb.push_back(data);
    endtask

    task automatic expectRedirect(input logic [31:0] target);
        expRedirect.push_back(target);
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic expectIllegal();
        expIllegal++;
    endtask

    task automatic endTest();
        if (expWb.size() != 0) noteError($sformatf("%0d write-backs never came", expWb.size()));
        if (expRedirect.size() != 0) begin
            noteError($sformatf("%0d redirects never came", expRedirect.size()));
        end
        if (expAddr.size() != 0) noteError($sformatf("%0d stores never came", expAddr.size()));
        if (expIllegal != 0) noteError($sformatf("%0d illegal strobes never came", expIllegal));
        testCount++;
        if (testErrors == 0) begin
            $display("test %0s: ok", testName);
        end else begin
            failCount++;
            $display("test %0s: failed with %0d errors", testName, testErrors);
        end
        expRd.delete();
        expWb.delete();
        expRedirect.delete();
        expAddr.delete();
        expData.delete();
        expIllegal = 0;
    endtask

    // outputs are registered on the rising edge, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (!arstN) begin
            if (wbValid || redirectValid || storeValid || illegal) begin
                noteError("an output strobe is active while reset is held");
            end
        end else begin
            if (wbValid) begin
                if (expWb.size() == 0) begin
                    noteError($sformatf("write-back to x%0d that nothing asked for", wbRd));
                end else begin
                    checkValue("wbRd", {27'b0, expRd.pop_front()}, {27'b0, wbRd});
                    checkValue("wbData", expWb.pop_front(), wbData);
                end
            end
            if (redirectValid) begin
                if (expRedirect.size() == 0) noteError("redirect that nothing asked for");
                else checkValue("redirectPc", expRedirect.pop_front(), redirectPc);
            end
            if (storeValid) begin
                if (expAddr.size() == 0) begin
                    noteError("store that nothing asked for");
                end else begin
                    checkValue("storeAddr", expAddr.pop_front(), storeAddr);
                    checkValue("storeData", expData.pop_front(), storeData);
                end
            end
            if (illegal) begin
                if (expIllegal == 0) noteError("illegal strobe that nothing asked for");
                else expIllegal--;
            end
        end
    end

endmodule

// File: tests/coreTb.sv
module coreTb;

    localparam int clkPeriod = 4;

    logic        clk;
    logic        arstN;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wbValid, redirectValid, storeValid, illegal;
    logic [4:0]  wbRd;
    logic [31:0] wbData, redirectPc, storeAddr, storeData;

    // the vector file is loaded whole, so the watchdog knows the run length up front.
    logic [7:0]      recKind [$];
    logic [31:0]     recA [$];
    logic [31:0]     recB [$];
    logic [8*16-1:0] recName [$];
    int              instrCount = 0;
    bit              loaded = 1'b0;
    logic [15:0]     lfsr;

    coreTop UUT (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr), .pc(pc),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData),
        .redirectValid(redirectValid), .redirectPc(redirectPc),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData),
        .illegal(illegal)
    );

    coreChecker chk (
        .clk(clk), .arstN(arstN), .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData),
        .redirectValid(redirectValid), .redirectPc(redirectPc),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData),
        .illegal(illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // the feedback polynomial is x^16 + x^14 + x^13 + x^11 and the new bit enters at the bottom.
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic idleGap();
        int gap;
        gap = 0;
        repeat (2) begin
            lfsr = lfsrStep(lfsr);
            gap  = gap * 2 + int'(lfsr[0]);
        end
        repeat (gap) @(negedge clk);
    endtask

    task automatic driveInstr(input logic [31:0] addr, input logic [31:0] word);
        idleGap();
        instrValid = 1'b1;
        pc         = addr;
        instr      = word;
        @(negedge clk);
        instrValid = 1'b0;
    endtask

    task automatic drainPipe();
        repeat (5) @(negedge clk);  // longest latency is 3 cycles.
    endtask

    initial begin
        int              fd;
        int              n;
        string           line;
        logic [7:0]      kind;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [8*16-1:0] name;
        bit              inTest;
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = 32'h0;
        pc         = 32'h0;
        lfsr       = 16'd14460;
        inTest     = 1'b0;
        a          = 32'h0;
        b          = 32'h0;
        name       = "";
        fd = $fopen("tests/core_vectors.txt", "r");
        if (fd == 0) begin
            chk.noteError("could not open the vector file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h", kind, a, b);
                    if (kind == "T") n = $sscanf(line, "%c %s", kind, name);
                    if (kind == "I") instrCount++;
                    recKind.push_back(kind);
                    recA.push_back(a);
                    recB.push_back(b);
                    recName.push_back(name);
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;

        // nothing may strobe while reset is held or right after it.
        chk.beginTest("reset");
        repeat (10) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        drainPipe();
        chk.endTest();

        foreach (recKind[i]) begin
            case (recKind[i])
                "T": begin
                    if (inTest) begin
                        drainPipe();
                        chk.endTest();
                    end
                    chk.beginTest(recName[i]);
                    inTest = 1'b1;
                end
                "I": driveInstr(recA[i], recB[i]);
                "W": chk.expectWb(recA[i][4:0], recB[i]);
                "R": chk.expectRedirect(recA[i]);
                "S": chk.expectStore(recA[i], recB[i]);
                "X": chk.expectIllegal();
                default: chk.noteError("vector file has a line of unknown kind");
            endcase
        end
        drainPipe();
        chk.endTest();

        $display("tests %0d, failed %0d, errors %0d, instructions %0d",
                 chk.testCount, chk.failCount, chk.errorCount, instrCount);
        if (chk.failCount == 0 && chk.errorCount == 0 && instrCount > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        #((instrCount * 7 + 50) * clkPeriod);
        $display("timeout, the run did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
rtl/corePkg.sv
rtl/mainController.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/resultStage.sv
rtl/coreTop.sv
tests/coreChecker.sv
tests/coreTb.sv

// File: Makefile
TOP = coreTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir -o coreSim
	./obj_dir/coreSim > sim.log 2>&1; cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: tests/core_vectors.txt
# T name | I pc instr | W rd data | R target | S addr data | X illegal strobe
# all numbers in hex, expected events follow the instruction that causes them
T alu
I 00000000 FF800093
W 01 FFFFFFF8
I 00000004 00500113
W 02 00000005
I 00000008 002081B3
W 03 FFFFFFFD
I 0000000C 40110233
W 04 0000000D
I 00000010 0020A2B3
W 05 00000001
I 00000014 0020B333
W 06 00000000
I 00000018 4010D393
W 07 FFFFFFFC
I 0000001C 0010D413
W 08 7FFFFFFC
I 00000020 0F014493
W 09 000000F5
I 00000024 0044E533
W 0A 000000FD
I 00000028 002575B3
W 0B 00000005
I 0000002C 00211633
W 0C 000000A0
I 00000030 00710013
T memory
I 00000040 00402423
S 00000008 0000000D
I 00000044 00702623
S 0000000C FFFFFFFC
I 00000048 00802683
W 0D 0000000D
I 0000004C 00D68733
W 0E 0000001A
I 00000050 00C02783
W 0F FFFFFFFC
I 00000054 00F02823
S 00000010 FFFFFFFC
T branch
I 00000100 00B10863
R 00000110
I 00000104 00B11863
I 00000108 FE20ACE3
R 00000100
I 0000010C 0020B863
I 00000110 00113863
R 00000120
T jump
I 00000200 12345837
W 10 12345000
I 00000204 020008EF
W 11 00000208
R 00000224
I 00000224 00610967
W 12 00000228
R 0000000A
I 0000000A 00190993
W 13 00000229
T illegal
I 00000300 0000007F
X
I 00000304 00B16863
X
I 00000308 00100A13
W 14 00000001
